// File: rtl/axi_mem_settings.svh
`ifndef AXI_MEM_SETTINGS_SVH
`define AXI_MEM_SETTINGS_SVH

// byte address width
`define AXI_MEM_ADDR_W 32

// data width, strobe is one bit per byte
`define AXI_MEM_DATA_W 64
`define AXI_MEM_STRB_W (`AXI_MEM_DATA_W / 8)

// 1024 words of 64 bits, index is addr[12:3]
`define AXI_MEM_DEPTH_LOG2 10

`endif

// File: rtl/axi_mem_pkg.sv
`default_nettype none

`include "axi_mem_settings.svh"

package axi_mem_pkg;

  // read or write address word
  typedef struct packed {
    logic [`AXI_MEM_ADDR_W-1:0] addr;
  } ax_req_t;

  // write data beat
  typedef struct packed {
    logic [`AXI_MEM_DATA_W-1:0] data;
    logic [`AXI_MEM_STRB_W-1:0] strb;
  } w_req_t;

  // AXI response encoding, only OKAY is ever driven
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } resp_e;

  // read data beat
  typedef struct packed {
    logic [`AXI_MEM_DATA_W-1:0] data;
    resp_e                      resp;
  } r_resp_t;

endpackage

`default_nettype wire

// File: rtl/mem_array.sv
`timescale 1ns/100ps
`default_nettype none

`include "axi_mem_settings.svh"

module mem_array (
  input  wire logic                           clk,
  input  wire logic                           rd_en_i,
  input  wire logic [`AXI_MEM_DEPTH_LOG2-1:0] rd_idx_i,
  output logic      [`AXI_MEM_DATA_W-1:0]     rd_data_o,
  input  wire logic                           wr_en_i,
  input  wire logic [`AXI_MEM_DEPTH_LOG2-1:0] wr_idx_i,
  input  wire logic [`AXI_MEM_DATA_W-1:0]     wr_data_i,
  input  wire logic [`AXI_MEM_STRB_W-1:0]     wr_strb_i
);

  localparam int WORDS = 1 << `AXI_MEM_DEPTH_LOG2;

  logic [`AXI_MEM_DATA_W-1:0] mem [0:WORDS-1];

  // read port holds its last word while rd_en_i is low
  always_ff @(posedge clk) begin
    if (rd_en_i) begin
      rd_data_o <= mem[rd_idx_i];
    end
  end

  // byte lanes written only where strobed
  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      for (int b = 0; b < `AXI_MEM_STRB_W; b++) begin
        if (wr_strb_i[b]) begin
          mem[wr_idx_i][b*8 +: 8] <= wr_data_i[b*8 +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/axi_mem_slave.sv
`timescale 1ns/100ps
`default_nettype none

`include "axi_mem_settings.svh"

module axi_mem_slave (
  input  wire logic                           clk,
  input  wire logic                           rst,
  // write address
  input  wire logic                           aw_valid_i,
  output logic                                aw_ready_o,
  input  wire axi_mem_pkg::ax_req_t           aw_req_i,
  // write data
  input  wire logic                           w_valid_i,
  output logic                                w_ready_o,
  input  wire axi_mem_pkg::w_req_t            w_req_i,
  // write response
  output logic                                b_valid_o,
  input  wire logic                           b_ready_i,
  output axi_mem_pkg::resp_e                  b_resp_o,
  // read address
  input  wire logic                           ar_valid_i,
  output logic                                ar_ready_o,
  input  wire axi_mem_pkg::ax_req_t           ar_req_i,
  // read data
  output logic                                r_valid_o,
  input  wire logic                           r_ready_i,
  output axi_mem_pkg::r_resp_t                r_resp_o,
  // array side
  output logic                                mem_rd_en_o,
  output logic      [`AXI_MEM_DEPTH_LOG2-1:0] mem_rd_idx_o,
  input  wire logic [`AXI_MEM_DATA_W-1:0]     mem_rd_data_i,
  output logic                                mem_wr_en_o,
  output logic      [`AXI_MEM_DEPTH_LOG2-1:0] mem_wr_idx_o,
  output logic      [`AXI_MEM_DATA_W-1:0]     mem_wr_data_o,
  output logic      [`AXI_MEM_STRB_W-1:0]     mem_wr_strb_o
);

  localparam int IDX_W  = `AXI_MEM_DEPTH_LOG2;
  // byte offset bits dropped by the 8-byte alignment
  localparam int OFFS_W = $clog2(`AXI_MEM_STRB_W);

  typedef enum logic [1:0] {
    W_IDLE,
    W_DATA,
    W_RESP
  } w_state_e;

  typedef enum logic [1:0] {
    R_IDLE,
    R_WAIT,
    R_RESP
  } r_state_e;

  w_state_e                   w_state_q;
  r_state_e                   r_state_q;
  logic [IDX_W-1:0]           wr_idx_q;
  axi_mem_pkg::w_req_t        w_req_q;
  logic [`AXI_MEM_DATA_W-1:0] r_data_q;

  logic aw_fire;
  logic w_fire;
  logic b_fire;
  logic ar_fire;
  logic r_fire;

  // handshakes straight from the state
  assign aw_ready_o = (w_state_q == W_IDLE);
  assign w_ready_o  = (w_state_q == W_DATA);
  assign b_valid_o  = (w_state_q == W_RESP);
  assign ar_ready_o = (r_state_q == R_IDLE);
  assign r_valid_o  = (r_state_q == R_RESP);

  assign aw_fire = aw_valid_i & aw_ready_o;
  assign w_fire  = w_valid_i & w_ready_o;
  assign b_fire  = b_valid_o & b_ready_i;
  assign ar_fire = ar_valid_i & ar_ready_o;
  assign r_fire  = r_valid_o & r_ready_i;

  // write machine
  always_ff @(posedge clk) begin
    if (rst) begin
      w_state_q <= W_IDLE;
    end else begin
      case (w_state_q)
        W_IDLE: if (aw_fire) w_state_q <= W_DATA;
        W_DATA: if (w_fire) w_state_q <= W_RESP;
        W_RESP: if (b_fire) w_state_q <= W_IDLE;
        default: w_state_q <= W_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (aw_fire) begin
      wr_idx_q <= aw_req_i.addr[OFFS_W +: IDX_W];
    end
    if (w_fire) begin
      w_req_q <= w_req_i;
    end
  end

  // commit happens on the b handshake
  assign mem_wr_en_o   = b_fire;
  assign mem_wr_idx_o  = wr_idx_q;
  assign mem_wr_data_o = w_req_q.data;
  assign mem_wr_strb_o = w_req_q.strb;
  assign b_resp_o      = axi_mem_pkg::RESP_OKAY;

  // read machine
  always_ff @(posedge clk) begin
    if (rst) begin
      r_state_q <= R_IDLE;
    end else begin
      case (r_state_q)
        R_IDLE: if (ar_fire) r_state_q <= R_WAIT;
        R_WAIT: r_state_q <= R_RESP;
        R_RESP: if (r_fire) r_state_q <= R_IDLE;
        default: r_state_q <= R_IDLE;
      endcase
    end
  end

  // array read issued as the address is accepted
  assign mem_rd_en_o  = ar_fire;
  assign mem_rd_idx_o = ar_req_i.addr[OFFS_W +: IDX_W];

  // word from the array lands during wait, held until accepted
  always_ff @(posedge clk) begin
    if (r_state_q == R_WAIT) begin
      r_data_q <= mem_rd_data_i;
    end
  end

  assign r_resp_o.data = r_data_q;
  assign r_resp_o.resp = axi_mem_pkg::RESP_OKAY;

endmodule

`default_nettype wire

// File: rtl/axi_read_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module axi_read_arbiter (
  input  wire logic                 clk,
  input  wire logic                 rst,
  // master 0
  input  wire logic                 m0_ar_valid_i,
  output logic                      m0_ar_ready_o,
  input  wire axi_mem_pkg::ax_req_t m0_ar_req_i,
  output logic                      m0_r_valid_o,
  input  wire logic                 m0_r_ready_i,
  output axi_mem_pkg::r_resp_t      m0_r_resp_o,
  // master 1
  input  wire logic                 m1_ar_valid_i,
  output logic                      m1_ar_ready_o,
  input  wire axi_mem_pkg::ax_req_t m1_ar_req_i,
  output logic                      m1_r_valid_o,
  input  wire logic                 m1_r_ready_i,
  output axi_mem_pkg::r_resp_t      m1_r_resp_o,
  // slave side
  output logic                      s_ar_valid_o,
  input  wire logic                 s_ar_ready_i,
  output axi_mem_pkg::ax_req_t      s_ar_req_o,
  input  wire logic                 s_r_valid_i,
  output logic                      s_r_ready_o,
  input  wire axi_mem_pkg::r_resp_t s_r_resp_i
);

  logic busy_q;
  logic owner_q;
  logic prio_q;
  logic pick;
  logic grant;

  // prio_q marks which master wins a tie
  assign pick  = (m0_ar_valid_i & m1_ar_valid_i) ? prio_q : m1_ar_valid_i;
  assign grant = ~busy_q & s_ar_ready_i;

  assign s_ar_valid_o  = ~busy_q & (m0_ar_valid_i | m1_ar_valid_i);
  assign s_ar_req_o    = pick ? m1_ar_req_i : m0_ar_req_i;
  // only the master that loses to the other sees ready low
  assign m0_ar_ready_o = grant & ~pick;
  assign m1_ar_ready_o = grant & (pick | ~m0_ar_valid_i);

  // data goes back to the owner only
  assign m0_r_valid_o = s_r_valid_i & busy_q & ~owner_q;
  assign m1_r_valid_o = s_r_valid_i & busy_q & owner_q;
  assign m0_r_resp_o  = s_r_resp_i;
  assign m1_r_resp_o  = s_r_resp_i;
  assign s_r_ready_o  = busy_q & (owner_q ? m1_r_ready_i : m0_r_ready_i);

  // lock from ar transfer until r transfer
  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q  <= 1'b0;
      owner_q <= 1'b0;
      prio_q  <= 1'b0;
    end else if (s_ar_valid_o & s_ar_ready_i & ~busy_q) begin
      busy_q  <= 1'b1;
      owner_q <= pick;
    end else if (s_r_valid_i & s_r_ready_o) begin
      busy_q <= 1'b0;
      // other master first next time
      prio_q <= ~owner_q;
    end
  end

endmodule

`default_nettype wire

// File: rtl/axi_mem_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "axi_mem_settings.svh"

module axi_mem_top (
  input  wire logic                 clk,
  input  wire logic                 rst,
  // instruction fetch
  input  wire logic                 ifu_ar_valid_i,
  output logic                      ifu_ar_ready_o,
  input  wire axi_mem_pkg::ax_req_t ifu_ar_req_i,
  output logic                      ifu_r_valid_o,
  input  wire logic                 ifu_r_ready_i,
  output axi_mem_pkg::r_resp_t      ifu_r_resp_o,
  // load/store reads
  input  wire logic                 lsu_ar_valid_i,
  output logic                      lsu_ar_ready_o,
  input  wire axi_mem_pkg::ax_req_t lsu_ar_req_i,
  output logic                      lsu_r_valid_o,
  input  wire logic                 lsu_r_ready_i,
  output axi_mem_pkg::r_resp_t      lsu_r_resp_o,
  // load/store writes
  input  wire logic                 lsu_aw_valid_i,
  output logic                      lsu_aw_ready_o,
  input  wire axi_mem_pkg::ax_req_t lsu_aw_req_i,
  input  wire logic                 lsu_w_valid_i,
  output logic                      lsu_w_ready_o,
  input  wire axi_mem_pkg::w_req_t  lsu_w_req_i,
  output logic                      lsu_b_valid_o,
  input  wire logic                 lsu_b_ready_i,
  output axi_mem_pkg::resp_e        lsu_b_resp_o
);

  // merged read channel into the slave
  logic                 s_ar_valid;
  logic                 s_ar_ready;
  axi_mem_pkg::ax_req_t s_ar_req;
  logic                 s_r_valid;
  logic                 s_r_ready;
  axi_mem_pkg::r_resp_t s_r_resp;

  logic                           mem_rd_en;
  logic [`AXI_MEM_DEPTH_LOG2-1:0] mem_rd_idx;
  logic [`AXI_MEM_DATA_W-1:0]     mem_rd_data;
  logic                           mem_wr_en;
  logic [`AXI_MEM_DEPTH_LOG2-1:0] mem_wr_idx;
  logic [`AXI_MEM_DATA_W-1:0]     mem_wr_data;
  logic [`AXI_MEM_STRB_W-1:0]     mem_wr_strb;

  // m0 is fetch, m1 is load/store
  axi_read_arbiter i_arbiter (
    .clk           (clk),
    .rst           (rst),
    .m0_ar_valid_i (ifu_ar_valid_i),
    .m0_ar_ready_o (ifu_ar_ready_o),
    .m0_ar_req_i   (ifu_ar_req_i),
    .m0_r_valid_o  (ifu_r_valid_o),
    .m0_r_ready_i  (ifu_r_ready_i),
    .m0_r_resp_o   (ifu_r_resp_o),
    .m1_ar_valid_i (lsu_ar_valid_i),
    .m1_ar_ready_o (lsu_ar_ready_o),
    .m1_ar_req_i   (lsu_ar_req_i),
    .m1_r_valid_o  (lsu_r_valid_o),
    .m1_r_ready_i  (lsu_r_ready_i),
    .m1_r_resp_o   (lsu_r_resp_o),
    .s_ar_valid_o  (s_ar_valid),
    .s_ar_ready_i  (s_ar_ready),
    .s_ar_req_o    (s_ar_req),
    .s_r_valid_i   (s_r_valid),
    .s_r_ready_o   (s_r_ready),
    .s_r_resp_i    (s_r_resp)
  );

  axi_mem_slave i_slave (
    .clk           (clk),
    .rst           (rst),
    .aw_valid_i    (lsu_aw_valid_i),
    .aw_ready_o    (lsu_aw_ready_o),
    .aw_req_i      (lsu_aw_req_i),
    .w_valid_i     (lsu_w_valid_i),
    .w_ready_o     (lsu_w_ready_o),
    .w_req_i       (lsu_w_req_i),
    .b_valid_o     (lsu_b_valid_o),
    .b_ready_i     (lsu_b_ready_i),
    .b_resp_o      (lsu_b_resp_o),
    .ar_valid_i    (s_ar_valid),
    .ar_ready_o    (s_ar_ready),
    .ar_req_i      (s_ar_req),
    .r_valid_o     (s_r_valid),
    .r_ready_i     (s_r_ready),
    .r_resp_o      (s_r_resp),
    .mem_rd_en_o   (mem_rd_en),
    .mem_rd_idx_o  (mem_rd_idx),
    .mem_rd_data_i (mem_rd_data),
    .mem_wr_en_o   (mem_wr_en),
    .mem_wr_idx_o  (mem_wr_idx),
    .mem_wr_data_o (mem_wr_data),
    .mem_wr_strb_o (mem_wr_strb)
  );

  mem_array i_array (
    .clk       (clk),
    .rd_en_i   (mem_rd_en),
    .rd_idx_i  (mem_rd_idx),
    .rd_data_o (mem_rd_data),
    .wr_en_i   (mem_wr_en),
    .wr_idx_i  (mem_wr_idx),
    .wr_data_i (mem_wr_data),
    .wr_strb_i (mem_wr_strb)
  );

endmodule

`default_nettype wire

// File: verification/tb_axi_mem.sv
`timescale 1ns/100ps
`default_nettype none

`include "axi_mem_settings.svh"

module tb_axi_mem;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 10;
  localparam int N_FULL       = 16;
  localparam int N_PART       = 16;
  localparam int N_BP         = 12;
  localparam int N_SHARED     = 12;
  // worst case cycles of one write or read, back-pressure included
  localparam int OP_CYCLES    = 24;
  localparam int TOTAL_OPS    = 2 * N_FULL + 3 * N_PART + 2 * N_BP + 2 * N_SHARED + 1;
  localparam int WATCHDOG_NS  = 4 * (RESET_CYCLES + TOTAL_OPS * OP_CYCLES) * CLK_PERIOD;

  logic                 clk = 1'b0;
  logic                 rst;
  logic                 ifu_ar_valid, ifu_ar_ready, ifu_r_valid, ifu_r_ready;
  axi_mem_pkg::ax_req_t ifu_ar_req;
  axi_mem_pkg::r_resp_t ifu_r_resp;
  logic                 lsu_ar_valid, lsu_ar_ready, lsu_r_valid, lsu_r_ready;
  axi_mem_pkg::ax_req_t lsu_ar_req;
  axi_mem_pkg::r_resp_t lsu_r_resp;
  logic                 lsu_aw_valid, lsu_aw_ready, lsu_w_valid, lsu_w_ready;
  logic                 lsu_b_valid, lsu_b_ready;
  axi_mem_pkg::ax_req_t lsu_aw_req;
  axi_mem_pkg::w_req_t  lsu_w_req;
  axi_mem_pkg::resp_e   lsu_b_resp;

  // byte-wide reference memory, index is addr[12:0] aligned to the word
  logic [7:0]  ref_mem [0:8191];
  logic [31:0] written_q [$];
  logic [31:0] ifu_addrs [N_SHARED];
  logic [31:0] lsu_addrs [N_SHARED];
  logic [31:0] lcg_state = 32'd29;
  logic [31:0] addr;
  logic [31:0] rnd;
  logic        ifu_pending, lsu_pending, last_lsu;
  string       cur_test = "reset";
  int          errors = 0;
  int          checks = 0;
  int          tests = 0;
  int          errors_at_start;

  always #(CLK_PERIOD / 2) clk = ~clk;

  axi_mem_top i_dut (
    .clk            (clk),
    .rst            (rst),
    .ifu_ar_valid_i (ifu_ar_valid),
    .ifu_ar_ready_o (ifu_ar_ready),
    .ifu_ar_req_i   (ifu_ar_req),
    .ifu_r_valid_o  (ifu_r_valid),
    .ifu_r_ready_i  (ifu_r_ready),
    .ifu_r_resp_o   (ifu_r_resp),
    .lsu_ar_valid_i (lsu_ar_valid),
    .lsu_ar_ready_o (lsu_ar_ready),
    .lsu_ar_req_i   (lsu_ar_req),
    .lsu_r_valid_o  (lsu_r_valid),
    .lsu_r_ready_i  (lsu_r_ready),
    .lsu_r_resp_o   (lsu_r_resp),
    .lsu_aw_valid_i (lsu_aw_valid),
    .lsu_aw_ready_o (lsu_aw_ready),
    .lsu_aw_req_i   (lsu_aw_req),
    .lsu_w_valid_i  (lsu_w_valid),
    .lsu_w_ready_o  (lsu_w_ready),
    .lsu_w_req_i    (lsu_w_req),
    .lsu_b_valid_o  (lsu_b_valid),
    .lsu_b_ready_i  (lsu_b_ready),
    .lsu_b_resp_o   (lsu_b_resp)
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [31:0] rand_addr();
    logic [31:0] r;
    r = lcg_next();
    return {19'd0, r[12:3], 3'd0};
  endfunction

  function automatic logic [63:0] rand_data();
    return {lcg_next(), lcg_next()};
  endfunction

  function automatic int rand_delay();
    logic [31:0] r;
    r = lcg_next();
    return {29'd0, r[2:0]} + 1;
  endfunction

  function automatic logic [31:0] rand_written();
    logic [31:0] r;
    r = lcg_next();
    return written_q[r % written_q.size()];
  endfunction

  function automatic void model_write(input logic [31:0] a, input logic [63:0] d,
                                      input logic [7:0] s);
    for (int b = 0; b < 8; b++) begin
      if (s[b]) begin
        ref_mem[{a[12:3], 3'(b)}] = d[b*8 +: 8];
      end
    end
  endfunction

  function automatic logic [63:0] model_word(input logic [31:0] a);
    logic [63:0] w;
    for (int b = 0; b < 8; b++) begin
      w[b*8 +: 8] = ref_mem[{a[12:3], 3'(b)}];
    end
    return w;
  endfunction

  task automatic report_err(input string what, input logic [63:0] exp, input logic [63:0] act);
    $display("ERR %s %s expected %h actual %h", cur_test, what, exp, act);
    errors++;
  endtask

  task automatic report_fault(input string what);
    $display("%s: %s", cur_test, what);
    errors++;
  endtask

  task automatic check_value(input string what, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    assert (act === exp) else report_err(what, exp, act);
  endtask

  task automatic lsu_write(input logic [31:0] a, input logic [63:0] d, input logic [7:0] s,
                           input int b_delay);
    lsu_aw_valid    <= 1'b1;
    lsu_aw_req.addr <= a;
    do begin @(posedge clk); end while (!lsu_aw_ready);
    lsu_aw_valid   <= 1'b0;
    lsu_w_valid    <= 1'b1;
    lsu_w_req.data <= d;
    lsu_w_req.strb <= s;
    do begin @(posedge clk); end while (!lsu_w_ready);
    lsu_w_valid <= 1'b0;
    do begin @(posedge clk); end while (!lsu_b_valid);
    repeat (b_delay) @(posedge clk);
    lsu_b_ready <= 1'b1;
    @(posedge clk);
    lsu_b_ready <= 1'b0;
    check_value("b resp", 64'(axi_mem_pkg::RESP_OKAY), 64'(lsu_b_resp));
    model_write(a, d, s);
  endtask

  task automatic lsu_read(input logic [31:0] a, input int r_delay);
    lsu_ar_valid    <= 1'b1;
    lsu_ar_req.addr <= a;
    do begin @(posedge clk); end while (!lsu_ar_ready);
    lsu_ar_valid <= 1'b0;
    do begin @(posedge clk); end while (!lsu_r_valid);
    repeat (r_delay) @(posedge clk);
    lsu_r_ready <= 1'b1;
    @(posedge clk);
    lsu_r_ready <= 1'b0;
    check_value("lsu read data", model_word(a), lsu_r_resp.data);
    check_value("lsu read resp", 64'(axi_mem_pkg::RESP_OKAY), 64'(lsu_r_resp.resp));
  endtask

  task automatic ifu_read(input logic [31:0] a);
    ifu_ar_valid    <= 1'b1;
    ifu_ar_req.addr <= a;
    do begin @(posedge clk); end while (!ifu_ar_ready);
    ifu_ar_valid <= 1'b0;
    do begin @(posedge clk); end while (!ifu_r_valid);
    ifu_r_ready <= 1'b1;
    @(posedge clk);
    ifu_r_ready <= 1'b0;
    check_value("ifu read data", model_word(a), ifu_r_resp.data);
    check_value("ifu read resp", 64'(axi_mem_pkg::RESP_OKAY), 64'(ifu_r_resp.resp));
  endtask

  task automatic start_test(input string name);
    cur_test        = name;
    errors_at_start = errors;
  endtask

  task automatic end_test();
    tests++;
    $display("%s finished with %0d errors", cur_test, errors - errors_at_start);
  endtask

  // outstanding reads per port and the last port granted
  always @(posedge clk) begin
    if (rst) begin
      ifu_pending <= 1'b0;
      lsu_pending <= 1'b0;
      last_lsu    <= 1'b1;
    end else begin
      if (ifu_ar_valid && ifu_ar_ready) begin
        ifu_pending <= 1'b1;
        last_lsu    <= 1'b0;
      end else if (ifu_r_valid && ifu_r_ready) begin
        ifu_pending <= 1'b0;
      end
      if (lsu_ar_valid && lsu_ar_ready) begin
        lsu_pending <= 1'b1;
        last_lsu    <= 1'b1;
      end else if (lsu_r_valid && lsu_r_ready) begin
        lsu_pending <= 1'b0;
      end
    end
  end

  a_lsu_r_late: assert property (@(posedge clk) disable iff (rst)
    $past(lsu_ar_valid && lsu_ar_ready, 2) |-> lsu_r_valid)
    else report_err("lsu r_valid two cycles after ar", 64'd1, 64'd0);
  a_lsu_r_early: assert property (@(posedge clk) disable iff (rst)
    $past(lsu_ar_valid && lsu_ar_ready) |-> !lsu_r_valid)
    else report_err("lsu r_valid one cycle after ar", 64'd0, 64'd1);
  a_ifu_r_late: assert property (@(posedge clk) disable iff (rst)
    $past(ifu_ar_valid && ifu_ar_ready, 2) |-> ifu_r_valid)
    else report_err("ifu r_valid two cycles after ar", 64'd1, 64'd0);
  a_lsu_r_hold: assert property (@(posedge clk) disable iff (rst)
    $past(lsu_r_valid && !lsu_r_ready) |-> lsu_r_valid && lsu_r_resp == $past(lsu_r_resp))
    else report_fault("lsu read data dropped or changed before it was accepted");
  a_ifu_r_hold: assert property (@(posedge clk) disable iff (rst)
    $past(ifu_r_valid && !ifu_r_ready) |-> ifu_r_valid && ifu_r_resp == $past(ifu_r_resp))
    else report_fault("ifu read data dropped or changed before it was accepted");
  a_b_hold: assert property (@(posedge clk) disable iff (rst)
    $past(lsu_b_valid && !lsu_b_ready) |-> lsu_b_valid && lsu_b_resp == $past(lsu_b_resp))
    else report_fault("write response dropped or changed before it was accepted");
  a_aw_blocked: assert property (@(posedge clk) disable iff (rst)
    lsu_b_valid |-> !lsu_aw_ready)
    else report_fault("new write address accepted while a response was pending");
  a_ar_blocked: assert property (@(posedge clk) disable iff (rst)
    lsu_r_valid |-> !lsu_ar_ready)
    else report_fault("new read address accepted while read data was pending");
  a_ifu_owned: assert property (@(posedge clk) disable iff (rst)
    ifu_r_valid |-> ifu_pending)
    else report_fault("fetch port got read data it never requested");
  a_lsu_owned: assert property (@(posedge clk) disable iff (rst)
    lsu_r_valid |-> lsu_pending)
    else report_fault("load/store port got read data it never requested");
  a_alternate: assert property (@(posedge clk) disable iff (rst)
    (ifu_ar_valid && lsu_ar_valid && (ifu_ar_ready || lsu_ar_ready)) |->
      (lsu_ar_ready == !last_lsu))
    else report_fault("both ports requested but the grant did not alternate");

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before all tests finished");
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    rst          = 1'b1;
    ifu_ar_valid = 1'b0;
    ifu_ar_req   = '0;
    ifu_r_ready  = 1'b0;
    lsu_ar_valid = 1'b0;
    lsu_ar_req   = '0;
    lsu_r_ready  = 1'b0;
    lsu_aw_valid = 1'b0;
    lsu_aw_req   = '0;
    lsu_w_valid  = 1'b0;
    lsu_w_req    = '0;
    lsu_b_ready  = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);

    start_test("reset_idle");
    check_value("aw_ready", 64'd1, 64'(lsu_aw_ready));
    check_value("lsu ar_ready", 64'd1, 64'(lsu_ar_ready));
    check_value("ifu ar_ready", 64'd1, 64'(ifu_ar_ready));
    check_value("w_ready", 64'd0, 64'(lsu_w_ready));
    check_value("b_valid", 64'd0, 64'(lsu_b_valid));
    check_value("ifu r_valid", 64'd0, 64'(ifu_r_valid));
    check_value("lsu r_valid", 64'd0, 64'(lsu_r_valid));
    end_test();

    start_test("write_read_full");
    for (int i = 0; i < N_FULL; i++) begin
      addr = rand_addr();
      lsu_write(addr, rand_data(), 8'hff, 0);
      written_q.push_back(addr);
      lsu_read(addr, 0);
    end
    end_test();

    start_test("partial_strobe");
    for (int i = 0; i < N_PART; i++) begin
      addr = rand_addr();
      rnd  = lcg_next();
      lsu_write(addr, rand_data(), 8'hff, 0);
      written_q.push_back(addr);
      lsu_write(addr | {29'd0, rnd[2:0]}, rand_data(), rnd[15:8], 0);
      lsu_read(addr | {29'd0, rnd[5:3]}, 0);
    end
    end_test();

    start_test("response_backpressure");
    for (int i = 0; i < N_BP; i++) begin
      addr = rand_addr();
      lsu_write(addr, rand_data(), 8'hff, rand_delay());
      written_q.push_back(addr);
      lsu_read(addr, rand_delay());
    end
    end_test();

    start_test("shared_reads");
    for (int i = 0; i < N_SHARED; i++) begin
      ifu_addrs[i] = rand_written();
      lsu_addrs[i] = rand_written();
    end
    fork
      begin
        for (int i = 0; i < N_SHARED; i++) begin
          ifu_read(ifu_addrs[i]);
        end
      end
      begin
        for (int i = 0; i < N_SHARED; i++) begin
          lsu_read(lsu_addrs[i], 0);
        end
      end
    join
    end_test();

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: axi_mem_top.f
+incdir+rtl
rtl/axi_mem_pkg.sv
rtl/mem_array.sv
rtl/axi_mem_slave.sv
rtl/axi_read_arbiter.sv
rtl/axi_mem_top.sv
verification/tb_axi_mem.sv

// File: run_sim.sh
#!/bin/sh
# compile the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_axi_mem -f axi_mem_top.f -o sim_axi_mem
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

out=$(./obj_dir/sim_axi_mem)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "TEST PASS"; then
  exit 0
fi
exit 1
